//--- verilog/mm_pkg.sv
package mm_pkg;

  // APB bus and configuration register widths
  localparam int REG_DATAWIDTH     = 32;
  localparam int REG_ADDRWIDTH     = 8;
  localparam int AWIDTH            = 16;
  localparam int ADDR_STRIDE_WIDTH = 16;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////
  // Start and clear-done on write, done and busy on read
  localparam logic [REG_ADDRWIDTH-1:0] REG_STDN_TPU_ADDR        = 8'h04;
  localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_A_ADDR        = 8'h0e;
  localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_B_ADDR        = 8'h12;
  localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_C_ADDR        = 8'h16;
  localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_A_STRIDE_ADDR = 8'h28;
  localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_B_STRIDE_ADDR = 8'h32;
  localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_C_STRIDE_ADDR = 8'h03;

  // Host port memory select codes
  localparam logic [7:0] SEL_A = 8'd0;
  localparam logic [7:0] SEL_B = 8'd1;
  localparam logic [7:0] SEL_C = 8'd2;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_W_ENABLE,
    APB_R_ENABLE
  } apb_state_t;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_RUN,
    CTRL_DONE
  } ctrl_state_t;

endpackage

//--- verilog/mm_row_ram.sv
`timescale 1ns/1ps

module mm_row_ram #(
  parameter int MAT_MUL_SIZE = 4,
  parameter int DWIDTH       = 8,
  parameter int RAM_AWIDTH   = 8
) (
  input  logic                           clk,
  input  logic [RAM_AWIDTH-1:0]          addr0,
  input  logic [MAT_MUL_SIZE*DWIDTH-1:0] d0,
  input  logic [MAT_MUL_SIZE-1:0]        we0,
  input  logic [RAM_AWIDTH-1:0]          addr1,
  input  logic [MAT_MUL_SIZE*DWIDTH-1:0] d1,
  input  logic [MAT_MUL_SIZE-1:0]        we1,
  output logic [MAT_MUL_SIZE*DWIDTH-1:0] q0,
  output logic [MAT_MUL_SIZE*DWIDTH-1:0] q1
);

  // One matrix row per word
  logic [MAT_MUL_SIZE*DWIDTH-1:0] mem [2**RAM_AWIDTH];

  // Port 1 wins if both ports hit the same element
  always_ff @(posedge clk) begin
    for (int i = 0; i < MAT_MUL_SIZE; i++) begin
      if (we0[i]) begin
        mem[addr0][i*DWIDTH +: DWIDTH] <= d0[i*DWIDTH +: DWIDTH];
      end
      if (we1[i]) begin
        mem[addr1][i*DWIDTH +: DWIDTH] <= d1[i*DWIDTH +: DWIDTH];
      end
    end
    q0 <= mem[addr0];
    q1 <= mem[addr1];
  end

  // Engine and host must not write one word together
  a_write_collision: assert property (@(posedge clk)
    (|we0) && (|we1) |-> addr0 != addr1)
    else $error("mm_row_ram: both ports write word %0h", addr0);

endmodule

//--- verilog/mm_matrix_store.sv
`timescale 1ns/1ps

module mm_matrix_store #(
  parameter int MAT_MUL_SIZE = 4,
  parameter int DWIDTH       = 8,
  parameter int RAM_AWIDTH   = 8
) (
  input  logic                           clk,
  input  logic [RAM_AWIDTH-1:0]          a_addr,
  input  logic [RAM_AWIDTH-1:0]          b_addr,
  input  logic [RAM_AWIDTH-1:0]          c_addr,
  input  logic [MAT_MUL_SIZE*DWIDTH-1:0] c_wdata,
  input  logic [MAT_MUL_SIZE-1:0]        c_we,
  input  logic [7:0]                     bram_select,
  input  logic [RAM_AWIDTH-1:0]          bram_addr_ext,
  input  logic [MAT_MUL_SIZE*DWIDTH-1:0] bram_wdata_ext,
  input  logic [MAT_MUL_SIZE-1:0]        bram_we_ext,
  output logic [MAT_MUL_SIZE*DWIDTH-1:0] a_rdata,
  output logic [MAT_MUL_SIZE*DWIDTH-1:0] b_rdata,
  output logic [MAT_MUL_SIZE*DWIDTH-1:0] bram_rdata_ext
);

  logic [7:0]                     select_q;
  logic [MAT_MUL_SIZE-1:0]        we_ext_a;
  logic [MAT_MUL_SIZE-1:0]        we_ext_b;
  logic [MAT_MUL_SIZE-1:0]        we_ext_c;
  logic [MAT_MUL_SIZE*DWIDTH-1:0] q1_a;
  logic [MAT_MUL_SIZE*DWIDTH-1:0] q1_b;
  logic [MAT_MUL_SIZE*DWIDTH-1:0] q1_c;

  // Host writes reach only the selected memory
  assign we_ext_a = (bram_select == mm_pkg::SEL_A) ? bram_we_ext : '0;
  assign we_ext_b = (bram_select == mm_pkg::SEL_B) ? bram_we_ext : '0;
  assign we_ext_c = (bram_select == mm_pkg::SEL_C) ? bram_we_ext : '0;

  // Read data lags the address by one cycle
  always_ff @(posedge clk) begin
    select_q <= bram_select;
  end

  always_comb begin
    case (select_q)
      mm_pkg::SEL_A: bram_rdata_ext = q1_a;
      mm_pkg::SEL_B: bram_rdata_ext = q1_b;
      mm_pkg::SEL_C: bram_rdata_ext = q1_c;
      default:       bram_rdata_ext = '0;
    endcase
  end

  mm_row_ram #(.MAT_MUL_SIZE(MAT_MUL_SIZE), .DWIDTH(DWIDTH), .RAM_AWIDTH(RAM_AWIDTH)) u_ram_a (
    .clk(clk), .addr0(a_addr), .d0('0), .we0('0), .q0(a_rdata),
    .addr1(bram_addr_ext), .d1(bram_wdata_ext), .we1(we_ext_a), .q1(q1_a)
  );

  mm_row_ram #(.MAT_MUL_SIZE(MAT_MUL_SIZE), .DWIDTH(DWIDTH), .RAM_AWIDTH(RAM_AWIDTH)) u_ram_b (
    .clk(clk), .addr0(b_addr), .d0('0), .we0('0), .q0(b_rdata),
    .addr1(bram_addr_ext), .d1(bram_wdata_ext), .we1(we_ext_b), .q1(q1_b)
  );

  // C is written by the engine and only read back by the host
  mm_row_ram #(.MAT_MUL_SIZE(MAT_MUL_SIZE), .DWIDTH(DWIDTH), .RAM_AWIDTH(RAM_AWIDTH)) u_ram_c (
    .clk(clk), .addr0(c_addr), .d0(c_wdata), .we0(c_we), .q0(),
    .addr1(bram_addr_ext), .d1(bram_wdata_ext), .we1(we_ext_c), .q1(q1_c)
  );

endmodule

//--- verilog/mm_apb_regs.sv
`timescale 1ns/1ps

module mm_apb_regs #(
  parameter int MAT_MUL_SIZE = 4
) (
  input  logic                                 clk,
  input  logic                                 PRESETn,
  input  logic [mm_pkg::REG_ADDRWIDTH-1:0]     PADDR,
  input  logic                                 PWRITE,
  input  logic                                 PSEL,
  input  logic                                 PENABLE,
  input  logic [mm_pkg::REG_DATAWIDTH-1:0]     PWDATA,
  input  logic                                 run_done,
  output logic [mm_pkg::REG_DATAWIDTH-1:0]     PRDATA,
  output logic                                 PREADY,
  output logic                                 run_start,
  output logic [mm_pkg::AWIDTH-1:0]            address_mat_a,
  output logic [mm_pkg::AWIDTH-1:0]            address_mat_b,
  output logic [mm_pkg::AWIDTH-1:0]            address_mat_c,
  output logic [mm_pkg::ADDR_STRIDE_WIDTH-1:0] address_stride_a,
  output logic [mm_pkg::ADDR_STRIDE_WIDTH-1:0] address_stride_b,
  output logic [mm_pkg::ADDR_STRIDE_WIDTH-1:0] address_stride_c
);

  localparam int DW = mm_pkg::REG_DATAWIDTH;
  localparam int AW = mm_pkg::AWIDTH;
  localparam int SW = mm_pkg::ADDR_STRIDE_WIDTH;
  localparam logic [SW-1:0] STRIDE_ONE = 1;
  // run_start to run_done through fetch, memory, dot product and writer
  localparam int RUN_CYCLES = MAT_MUL_SIZE * MAT_MUL_SIZE + 5;

  mm_pkg::apb_state_t  apb_state;
  mm_pkg::ctrl_state_t ctrl_state;
  logic                wr_access;
  logic                rd_access;
  logic                stdn_wr;
  logic [DW-1:0]       rdata_mux;
  logic [15:0]         run_cycles;

  assign wr_access = (apb_state == mm_pkg::APB_W_ENABLE) && PSEL && PENABLE && PWRITE;
  assign rd_access = (apb_state == mm_pkg::APB_R_ENABLE) && PSEL && PENABLE && !PWRITE;
  assign stdn_wr   = wr_access && (PADDR == mm_pkg::REG_STDN_TPU_ADDR);

  ////////////////////////////////////////////////////////////
  // APB access
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      apb_state <= mm_pkg::APB_IDLE;
      PREADY    <= 1'b0;
      PRDATA    <= '0;
    end else begin
      PREADY <= wr_access || rd_access;
      PRDATA <= rd_access ? rdata_mux : '0;
      case (apb_state)
        mm_pkg::APB_IDLE: begin
          if (PSEL) begin
            apb_state <= PWRITE ? mm_pkg::APB_W_ENABLE : mm_pkg::APB_R_ENABLE;
          end
        end
        default: apb_state <= mm_pkg::APB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      address_mat_a    <= '0;
      address_mat_b    <= '0;
      address_mat_c    <= '0;
      address_stride_a <= STRIDE_ONE;
      address_stride_b <= STRIDE_ONE;
      address_stride_c <= STRIDE_ONE;
    end else if (wr_access) begin
      case (PADDR)
        mm_pkg::REG_MATRIX_A_ADDR:        address_mat_a    <= PWDATA[AW-1:0];
        mm_pkg::REG_MATRIX_B_ADDR:        address_mat_b    <= PWDATA[AW-1:0];
        mm_pkg::REG_MATRIX_C_ADDR:        address_mat_c    <= PWDATA[AW-1:0];
        mm_pkg::REG_MATRIX_A_STRIDE_ADDR: address_stride_a <= PWDATA[SW-1:0];
        mm_pkg::REG_MATRIX_B_STRIDE_ADDR: address_stride_b <= PWDATA[SW-1:0];
        mm_pkg::REG_MATRIX_C_STRIDE_ADDR: address_stride_c <= PWDATA[SW-1:0];
        default: ;
      endcase
    end
  end

  // Undefined addresses read zero
  always_comb begin
    rdata_mux = '0;
    case (PADDR)
      mm_pkg::REG_STDN_TPU_ADDR: begin
        rdata_mux[DW-1] = (ctrl_state == mm_pkg::CTRL_DONE);
        rdata_mux[0]    = (ctrl_state == mm_pkg::CTRL_RUN);
      end
      mm_pkg::REG_MATRIX_A_ADDR:        rdata_mux[AW-1:0] = address_mat_a;
      mm_pkg::REG_MATRIX_B_ADDR:        rdata_mux[AW-1:0] = address_mat_b;
      mm_pkg::REG_MATRIX_C_ADDR:        rdata_mux[AW-1:0] = address_mat_c;
      mm_pkg::REG_MATRIX_A_STRIDE_ADDR: rdata_mux[SW-1:0] = address_stride_a;
      mm_pkg::REG_MATRIX_B_STRIDE_ADDR: rdata_mux[SW-1:0] = address_stride_b;
      mm_pkg::REG_MATRIX_C_STRIDE_ADDR: rdata_mux[SW-1:0] = address_stride_c;
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      ctrl_state <= mm_pkg::CTRL_IDLE;
      run_start  <= 1'b0;
      run_cycles <= '0;
    end else begin
      run_start <= 1'b0;
      case (ctrl_state)
        mm_pkg::CTRL_IDLE: begin
          if (stdn_wr && PWDATA[0]) begin
            ctrl_state <= mm_pkg::CTRL_RUN;
            run_start  <= 1'b1;
            run_cycles <= '0;
          end
        end
        mm_pkg::CTRL_RUN: begin
          run_cycles <= run_cycles + 16'd1;
          if (run_done) begin
            ctrl_state <= mm_pkg::CTRL_DONE;
          end
        end
        mm_pkg::CTRL_DONE: begin
          if (stdn_wr && PWDATA[DW-1]) begin
            ctrl_state <= mm_pkg::CTRL_IDLE;
          end
        end
        default: ctrl_state <= mm_pkg::CTRL_IDLE;
      endcase
    end
  end

  a_pready_pulse: assert property (@(posedge clk) disable iff (!PRESETn)
    PREADY |=> !PREADY);

  // Pipeline depth is fixed so done comes at a known cycle
  a_run_latency: assert property (@(posedge clk) disable iff (!PRESETn)
    run_done |-> ctrl_state == mm_pkg::CTRL_RUN && run_cycles == RUN_CYCLES);

endmodule

//--- verilog/mm_operand_fetch.sv
`timescale 1ns/1ps

module mm_operand_fetch #(
  parameter int MAT_MUL_SIZE = 4,
  parameter int RAM_AWIDTH   = 8
) (
  input  logic                                 clk,
  input  logic                                 PRESETn,
  input  logic                                 run_start,
  input  logic [mm_pkg::AWIDTH-1:0]            address_mat_a,
  input  logic [mm_pkg::AWIDTH-1:0]            address_mat_b,
  input  logic [mm_pkg::ADDR_STRIDE_WIDTH-1:0] address_stride_a,
  input  logic [mm_pkg::ADDR_STRIDE_WIDTH-1:0] address_stride_b,
  output logic [RAM_AWIDTH-1:0]                a_addr,
  output logic [RAM_AWIDTH-1:0]                b_addr,
  output logic                                 fetch_valid,
  output logic [$clog2(MAT_MUL_SIZE)-1:0]      fetch_row,
  output logic [$clog2(MAT_MUL_SIZE)-1:0]      fetch_col
);

  localparam int IW = $clog2(MAT_MUL_SIZE);
  localparam int AW = mm_pkg::AWIDTH;
  localparam logic [IW-1:0] LAST = IW'(MAT_MUL_SIZE - 1);

  logic          busy;
  logic [IW-1:0] row;
  logic [IW-1:0] col;
  logic [AW-1:0] a_full;
  logic [AW-1:0] b_full;

  // A word is row i and B word is column j since B is transposed
  assign a_full = address_mat_a + AW'(row) * address_stride_a;
  assign b_full = address_mat_b + AW'(col) * address_stride_b;
  assign a_addr = a_full[RAM_AWIDTH-1:0];
  assign b_addr = b_full[RAM_AWIDTH-1:0];

  // Row major walk with column as inner index
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      busy        <= 1'b0;
      row         <= '0;
      col         <= '0;
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= busy;
      if (run_start) begin
        busy <= 1'b1;
        row  <= '0;
        col  <= '0;
      end else if (busy) begin
        col <= col + 1'b1;
        if (col == LAST) begin
          col <= '0;
          row <= row + 1'b1;
          busy <= (row != LAST);
        end
      end
    end
  end

  // Tags follow the read data out of the memories
  always_ff @(posedge clk) begin
    fetch_row <= row;
    fetch_col <= col;
  end

  a_no_restart: assert property (@(posedge clk) disable iff (!PRESETn)
    run_start |-> !busy);

endmodule

//--- verilog/mm_dot_product.sv
`timescale 1ns/1ps

module mm_dot_product #(
  parameter int MAT_MUL_SIZE = 4,
  parameter int DWIDTH       = 8
) (
  input  logic                              clk,
  input  logic                              PRESETn,
  input  logic                              in_valid,
  input  logic [$clog2(MAT_MUL_SIZE)-1:0]   in_row,
  input  logic [$clog2(MAT_MUL_SIZE)-1:0]   in_col,
  input  logic [MAT_MUL_SIZE*DWIDTH-1:0]    a_row,
  input  logic [MAT_MUL_SIZE*DWIDTH-1:0]    b_col,
  output logic                              out_valid,
  output logic [$clog2(MAT_MUL_SIZE)-1:0]   out_row,
  output logic [$clog2(MAT_MUL_SIZE)-1:0]   out_col,
  output logic [DWIDTH-1:0]                 result
);

  localparam int IW = $clog2(MAT_MUL_SIZE);

  // Only the low DWIDTH bits of each product reach the truncated sum
  logic [DWIDTH-1:0] prod [MAT_MUL_SIZE];
  logic [DWIDTH-1:0] sum;
  logic              valid_s1;
  logic [IW-1:0]     row_s1;
  logic [IW-1:0]     col_s1;

  always_comb begin
    sum = '0;
    for (int k = 0; k < MAT_MUL_SIZE; k++) begin
      sum = sum + prod[k];
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < MAT_MUL_SIZE; k++) begin
      prod[k] <= a_row[k*DWIDTH +: DWIDTH] * b_col[k*DWIDTH +: DWIDTH];
    end
    row_s1  <= in_row;
    col_s1  <= in_col;
    result  <= sum;
    out_row <= row_s1;
    out_col <= col_s1;
  end

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      valid_s1  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      valid_s1  <= in_valid;
      out_valid <= valid_s1;
    end
  end

endmodule

//--- verilog/mm_result_writer.sv
`timescale 1ns/1ps

module mm_result_writer #(
  parameter int MAT_MUL_SIZE = 4,
  parameter int DWIDTH       = 8,
  parameter int RAM_AWIDTH   = 8
) (
  input  logic                                 clk,
  input  logic                                 PRESETn,
  input  logic                                 out_valid,
  input  logic [$clog2(MAT_MUL_SIZE)-1:0]      out_row,
  input  logic [$clog2(MAT_MUL_SIZE)-1:0]      out_col,
  input  logic [DWIDTH-1:0]                    result,
  input  logic [mm_pkg::AWIDTH-1:0]            address_mat_c,
  input  logic [mm_pkg::ADDR_STRIDE_WIDTH-1:0] address_stride_c,
  output logic [RAM_AWIDTH-1:0]                c_addr,
  output logic [MAT_MUL_SIZE*DWIDTH-1:0]       c_wdata,
  output logic [MAT_MUL_SIZE-1:0]              c_we,
  output logic                                 run_done
);

  localparam int IW = $clog2(MAT_MUL_SIZE);
  localparam int AW = mm_pkg::AWIDTH;
  localparam int W  = MAT_MUL_SIZE * DWIDTH;
  localparam logic [IW-1:0] LAST = IW'(MAT_MUL_SIZE - 1);

  logic [W-1:0]  row_buf;
  logic [AW-1:0] c_full;
  logic          row_end;
  logic          final_row_q;

  assign row_end = out_valid && (out_col == LAST);
  assign c_full  = address_mat_c + AW'(out_row) * address_stride_c;

  // Last element goes straight into the write word
  always_ff @(posedge clk) begin
    if (out_valid) begin
      row_buf[out_col*DWIDTH +: DWIDTH] <= result;
    end
    if (row_end) begin
      c_wdata <= {result, row_buf[W-DWIDTH-1:0]};
      c_addr  <= c_full[RAM_AWIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      c_we        <= '0;
      final_row_q <= 1'b0;
      run_done    <= 1'b0;
    end else begin
      c_we        <= {MAT_MUL_SIZE{row_end}};
      final_row_q <= row_end && (out_row == LAST);
      run_done    <= final_row_q;
    end
  end

  // Results of one row arrive back to back in column order
  a_col_order: assert property (@(posedge clk) disable iff (!PRESETn)
    out_valid && out_col != '0 |-> $past(out_valid) && out_col == $past(out_col) + 1'b1);

endmodule

//--- verilog/matrix_multiplication.sv
`timescale 1ns/1ps

module matrix_multiplication #(
  parameter int MAT_MUL_SIZE = 4,
  parameter int DWIDTH       = 8,
  parameter int RAM_AWIDTH   = 8
) (
  input  logic                             clk,
  input  logic                             PRESETn,
  input  logic [mm_pkg::REG_ADDRWIDTH-1:0] PADDR,
  input  logic                             PWRITE,
  input  logic                             PSEL,
  input  logic                             PENABLE,
  input  logic [mm_pkg::REG_DATAWIDTH-1:0] PWDATA,
  output logic [mm_pkg::REG_DATAWIDTH-1:0] PRDATA,
  output logic                             PREADY,
  input  logic [7:0]                       bram_select,
  input  logic [RAM_AWIDTH-1:0]            bram_addr_ext,
  input  logic [MAT_MUL_SIZE*DWIDTH-1:0]   bram_wdata_ext,
  input  logic [MAT_MUL_SIZE-1:0]          bram_we_ext,
  output logic [MAT_MUL_SIZE*DWIDTH-1:0]   bram_rdata_ext
);

  localparam int IW = $clog2(MAT_MUL_SIZE);

  logic                                 run_start;
  logic                                 run_done;
  logic [mm_pkg::AWIDTH-1:0]            address_mat_a;
  logic [mm_pkg::AWIDTH-1:0]            address_mat_b;
  logic [mm_pkg::AWIDTH-1:0]            address_mat_c;
  logic [mm_pkg::ADDR_STRIDE_WIDTH-1:0] address_stride_a;
  logic [mm_pkg::ADDR_STRIDE_WIDTH-1:0] address_stride_b;
  logic [mm_pkg::ADDR_STRIDE_WIDTH-1:0] address_stride_c;
  logic [RAM_AWIDTH-1:0]                a_addr;
  logic [RAM_AWIDTH-1:0]                b_addr;
  logic [RAM_AWIDTH-1:0]                c_addr;
  logic [MAT_MUL_SIZE*DWIDTH-1:0]       a_rdata;
  logic [MAT_MUL_SIZE*DWIDTH-1:0]       b_rdata;
  logic [MAT_MUL_SIZE*DWIDTH-1:0]       c_wdata;
  logic [MAT_MUL_SIZE-1:0]              c_we;
  logic                                 fetch_valid;
  logic [IW-1:0]                        fetch_row;
  logic [IW-1:0]                        fetch_col;
  logic                                 out_valid;
  logic [IW-1:0]                        out_row;
  logic [IW-1:0]                        out_col;
  logic [DWIDTH-1:0]                    result;

  ////////////////////////////////////////////////////////////
  // Configuration and run control
  ////////////////////////////////////////////////////////////
  mm_apb_regs #(.MAT_MUL_SIZE(MAT_MUL_SIZE)) u_apb_regs (
    .clk(clk), .PRESETn(PRESETn), .PADDR(PADDR), .PWRITE(PWRITE), .PSEL(PSEL),
    .PENABLE(PENABLE), .PWDATA(PWDATA), .run_done(run_done), .PRDATA(PRDATA),
    .PREADY(PREADY), .run_start(run_start), .address_mat_a(address_mat_a),
    .address_mat_b(address_mat_b), .address_mat_c(address_mat_c),
    .address_stride_a(address_stride_a), .address_stride_b(address_stride_b),
    .address_stride_c(address_stride_c)
  );

  mm_matrix_store #(.MAT_MUL_SIZE(MAT_MUL_SIZE), .DWIDTH(DWIDTH), .RAM_AWIDTH(RAM_AWIDTH))
  u_matrix_store (
    .clk(clk), .a_addr(a_addr), .b_addr(b_addr), .c_addr(c_addr), .c_wdata(c_wdata),
    .c_we(c_we), .bram_select(bram_select), .bram_addr_ext(bram_addr_ext),
    .bram_wdata_ext(bram_wdata_ext), .bram_we_ext(bram_we_ext), .a_rdata(a_rdata),
    .b_rdata(b_rdata), .bram_rdata_ext(bram_rdata_ext)
  );

  ////////////////////////////////////////////////////////////
  // Compute pipeline
  ////////////////////////////////////////////////////////////
  mm_operand_fetch #(.MAT_MUL_SIZE(MAT_MUL_SIZE), .RAM_AWIDTH(RAM_AWIDTH)) u_operand_fetch (
    .clk(clk), .PRESETn(PRESETn), .run_start(run_start), .address_mat_a(address_mat_a),
    .address_mat_b(address_mat_b), .address_stride_a(address_stride_a),
    .address_stride_b(address_stride_b), .a_addr(a_addr), .b_addr(b_addr),
    .fetch_valid(fetch_valid), .fetch_row(fetch_row), .fetch_col(fetch_col)
  );

  mm_dot_product #(.MAT_MUL_SIZE(MAT_MUL_SIZE), .DWIDTH(DWIDTH)) u_dot_product (
    .clk(clk), .PRESETn(PRESETn), .in_valid(fetch_valid), .in_row(fetch_row),
    .in_col(fetch_col), .a_row(a_rdata), .b_col(b_rdata), .out_valid(out_valid),
    .out_row(out_row), .out_col(out_col), .result(result)
  );

  mm_result_writer #(.MAT_MUL_SIZE(MAT_MUL_SIZE), .DWIDTH(DWIDTH), .RAM_AWIDTH(RAM_AWIDTH))
  u_result_writer (
    .clk(clk), .PRESETn(PRESETn), .out_valid(out_valid), .out_row(out_row),
    .out_col(out_col), .result(result), .address_mat_c(address_mat_c),
    .address_stride_c(address_stride_c), .c_addr(c_addr), .c_wdata(c_wdata),
    .c_we(c_we), .run_done(run_done)
  );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

//--- test/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
  parameter int MAT_MUL_SIZE = 4,
  parameter int DWIDTH       = 8,
  parameter int RAM_AWIDTH   = 8
) (
  input  logic                           clk,
  input  logic                           PRESETn,
  input  logic [7:0]                     PADDR,
  input  logic                           PWRITE,
  input  logic [31:0]                    PWDATA,
  input  logic [31:0]                    PRDATA,
  input  logic                           PREADY,
  input  logic [7:0]                     bram_select,
  input  logic [RAM_AWIDTH-1:0]          bram_addr_ext,
  input  logic [MAT_MUL_SIZE*DWIDTH-1:0] bram_wdata_ext,
  input  logic [MAT_MUL_SIZE-1:0]        bram_we_ext,
  input  logic [MAT_MUL_SIZE*DWIDTH-1:0] bram_rdata_ext,
  input  logic                           host_rd,
  output int                             errors,
  output int                             checks
);

  localparam int N = MAT_MUL_SIZE;
  localparam int W = MAT_MUL_SIZE * DWIDTH;
  // Run tracking
  localparam int ST_IDLE = 0;
  localparam int ST_RUN  = 1;
  localparam int ST_DONE = 2;
  // Done reaches the status register N*N+6 cycles after the start write
  // and a read returns the state of the cycle before its access edge
  localparam int DONE_DELAY = MAT_MUL_SIZE * MAT_MUL_SIZE + 7;

  logic [W-1:0]          pat [6*N];
  logic [W-1:0]          mem_shadow [3][2**RAM_AWIDTH];
  logic [31:0]           reg_shadow [256];
  int                    run_state;
  int                    runs;
  int                    cyc;
  int                    start_cyc;
  // Host port and APB activity captured at the rising edge
  logic                  wr_q;
  logic                  rd_q;
  logic [7:0]            sel_q;
  logic [RAM_AWIDTH-1:0] addr_q;
  logic [W-1:0]          wdata_q;
  logic [N-1:0]          we_q;
  logic [7:0]            paddr_q;
  logic                  pwrite_q;
  logic [31:0]           pwdata_q;

  initial begin
    $readmemh("test/mm_patterns.hex", pat);
    errors    = 0;
    checks    = 0;
    run_state = ST_IDLE;
    runs      = 0;
    cyc       = 0;
    start_cyc = 0;
    rd_q      = 1'b0;
    wr_q      = 1'b0;
    for (int a = 0; a < 256; a++) begin
      reg_shadow[a] = '0;
    end
    reg_shadow[mm_pkg::REG_MATRIX_A_STRIDE_ADDR] = 32'd1;
    reg_shadow[mm_pkg::REG_MATRIX_B_STRIDE_ADDR] = 32'd1;
    reg_shadow[mm_pkg::REG_MATRIX_C_STRIDE_ADDR] = 32'd1;
  end

  function automatic logic is_config(input logic [7:0] a);
    return a == mm_pkg::REG_MATRIX_A_ADDR || a == mm_pkg::REG_MATRIX_B_ADDR ||
           a == mm_pkg::REG_MATRIX_C_ADDR || a == mm_pkg::REG_MATRIX_A_STRIDE_ADDR ||
           a == mm_pkg::REG_MATRIX_B_STRIDE_ADDR || a == mm_pkg::REG_MATRIX_C_STRIDE_ADDR;
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, got);
    end
  endtask

  // Expected C rows of the run that just started
  task automatic load_expected_c();
    int base;
    int stride;
    base   = int'(reg_shadow[mm_pkg::REG_MATRIX_C_ADDR]);
    stride = int'(reg_shadow[mm_pkg::REG_MATRIX_C_STRIDE_ADDR]);
    for (int i = 0; i < N; i++) begin
      mem_shadow[2][RAM_AWIDTH'(base + i * stride)] = pat[runs * 3 * N + 2 * N + i];
    end
  endtask

  always @(posedge clk) begin
    cyc      <= cyc + 1;
    wr_q     <= PRESETn && (|bram_we_ext) && (bram_select < 8'd3);
    rd_q     <= PRESETn && host_rd;
    sel_q    <= bram_select;
    addr_q   <= bram_addr_ext;
    wdata_q  <= bram_wdata_ext;
    we_q     <= bram_we_ext;
    paddr_q  <= PADDR;
    pwrite_q <= PWRITE;
    pwdata_q <= PWDATA;
  end

  ////////////////////////////////////////////////////////////
  // Monitor, sampled mid cycle
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin : monitor
    logic [W-1:0]  exp_mem;
    logic [31:0]   exp_reg;
    if (run_state == ST_RUN && cyc - start_cyc >= DONE_DELAY) begin
      run_state = ST_DONE;
    end
    if (wr_q) begin
      for (int k = 0; k < N; k++) begin
        if (we_q[k]) begin
          mem_shadow[sel_q][addr_q][k*DWIDTH +: DWIDTH] = wdata_q[k*DWIDTH +: DWIDTH];
        end
      end
    end
    if (rd_q) begin
      exp_mem = (sel_q < 8'd3) ? mem_shadow[sel_q][addr_q] : '0;
      compare("bram_rdata_ext", 64'(exp_mem), 64'(bram_rdata_ext));
    end
    if (PRESETn && PREADY && pwrite_q) begin
      if (paddr_q == mm_pkg::REG_STDN_TPU_ADDR) begin
        if (pwdata_q[0] && run_state == ST_IDLE) begin
          load_expected_c();
          runs++;
          run_state = ST_RUN;
          start_cyc = cyc;
        end else if (pwdata_q[31] && run_state == ST_DONE) begin
          run_state = ST_IDLE;
        end
      end else if (is_config(paddr_q)) begin
        reg_shadow[paddr_q] = {16'h0, pwdata_q[15:0]};
      end
    end else if (PRESETn && PREADY) begin
      if (paddr_q == mm_pkg::REG_STDN_TPU_ADDR) begin
        case (run_state)
          ST_RUN:  exp_reg = 32'h1;
          ST_DONE: exp_reg = 32'h8000_0000;
          default: exp_reg = 32'h0;
        endcase
        compare("PRDATA status", 64'(exp_reg), 64'(PRDATA));
      end else begin
        compare("PRDATA", 64'(reg_shadow[paddr_q]), 64'(PRDATA));
      end
    end
  end

endmodule

//--- test/tb_matrix_multiplication.sv
`timescale 1ns/1ps

module tb_matrix_multiplication;

  localparam int N       = 4;
  localparam int DW      = 8;
  localparam int RAW     = 8;
  localparam int W       = N * DW;
  localparam int RUN_LEN = N * N + 6;
  localparam int XFERS   = 130;
  // Two runs plus every transfer at four cycles, five times over
  localparam int LIMIT   = 5 * (2 * RUN_LEN + 4 * XFERS);

  logic           clk;
  logic           PRESETn;
  logic [7:0]     PADDR;
  logic           PWRITE;
  logic           PSEL;
  logic           PENABLE;
  logic [31:0]    PWDATA;
  logic [31:0]    PRDATA;
  logic           PREADY;
  logic [7:0]     bram_select;
  logic [RAW-1:0] bram_addr_ext;
  logic [W-1:0]   bram_wdata_ext;
  logic [N-1:0]   bram_we_ext;
  logic [W-1:0]   bram_rdata_ext;
  logic           host_rd;
  int             errors;
  int             checks;
  int             cycles;
  logic [W-1:0]   pat [6*N];

  tb_clock_gen #(.PERIOD_NS(10)) u_clock_gen (.clk(clk));

  matrix_multiplication #(.MAT_MUL_SIZE(N), .DWIDTH(DW), .RAM_AWIDTH(RAW))
  u_matrix_multiplication (
    .clk(clk), .PRESETn(PRESETn), .PADDR(PADDR), .PWRITE(PWRITE), .PSEL(PSEL),
    .PENABLE(PENABLE), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
    .bram_select(bram_select), .bram_addr_ext(bram_addr_ext),
    .bram_wdata_ext(bram_wdata_ext), .bram_we_ext(bram_we_ext),
    .bram_rdata_ext(bram_rdata_ext)
  );

  tb_checker #(.MAT_MUL_SIZE(N), .DWIDTH(DW), .RAM_AWIDTH(RAW)) u_checker (
    .clk(clk), .PRESETn(PRESETn), .PADDR(PADDR), .PWRITE(PWRITE), .PWDATA(PWDATA),
    .PRDATA(PRDATA), .PREADY(PREADY), .bram_select(bram_select),
    .bram_addr_ext(bram_addr_ext), .bram_wdata_ext(bram_wdata_ext),
    .bram_we_ext(bram_we_ext), .bram_rdata_ext(bram_rdata_ext), .host_rd(host_rd),
    .errors(errors), .checks(checks)
  );

  ////////////////////////////////////////////////////////////
  // Bus tasks, each starts and ends on a falling edge
  ////////////////////////////////////////////////////////////
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    PSEL    = 1'b1;
    PWRITE  = 1'b1;
    PADDR   = addr;
    PWDATA  = data;
    PENABLE = 1'b0;
    @(negedge clk);
    PENABLE = 1'b1;
    @(negedge clk);
    while (!PREADY) @(negedge clk);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    PSEL    = 1'b1;
    PWRITE  = 1'b0;
    PADDR   = addr;
    PENABLE = 1'b0;
    @(negedge clk);
    PENABLE = 1'b1;
    @(negedge clk);
    while (!PREADY) @(negedge clk);
    data    = PRDATA;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic host_write(input logic [7:0] sel, input int addr, input logic [W-1:0] data);
    bram_select    = sel;
    bram_addr_ext  = RAW'(addr);
    bram_wdata_ext = data;
    bram_we_ext    = '1;
    @(negedge clk);
    bram_we_ext    = '0;
  endtask

  task automatic host_read(input logic [7:0] sel, input int addr);
    bram_select   = sel;
    bram_addr_ext = RAW'(addr);
    host_rd       = 1'b1;
    @(negedge clk);
    host_rd       = 1'b0;
  endtask

  // Load operands, run to done, then read everything back
  task automatic run_matrix(input int r, input int ab, input int bb, input int cb, input int st);
    logic [31:0] status;
    for (int i = 0; i < 2 * N; i++) begin
      host_write(mm_pkg::SEL_C, cb + i, {N{8'haa}});
    end
    for (int i = 0; i < N; i++) begin
      host_write(mm_pkg::SEL_A, ab + i * st, pat[r * 3 * N + i]);
      host_write(mm_pkg::SEL_B, bb + i * st, pat[r * 3 * N + N + i]);
    end
    apb_write(mm_pkg::REG_MATRIX_A_ADDR, ab);
    apb_write(mm_pkg::REG_MATRIX_B_ADDR, bb);
    apb_write(mm_pkg::REG_MATRIX_C_ADDR, cb);
    apb_write(mm_pkg::REG_MATRIX_A_STRIDE_ADDR, st);
    apb_write(mm_pkg::REG_MATRIX_B_STRIDE_ADDR, st);
    apb_write(mm_pkg::REG_MATRIX_C_STRIDE_ADDR, st);
    apb_write(mm_pkg::REG_STDN_TPU_ADDR, 32'h1);
    status = '0;
    while (!status[31]) apb_read(mm_pkg::REG_STDN_TPU_ADDR, status);
    // Done must hold until cleared
    apb_read(mm_pkg::REG_STDN_TPU_ADDR, status);
    apb_write(mm_pkg::REG_STDN_TPU_ADDR, 32'h8000_0000);
    apb_read(mm_pkg::REG_STDN_TPU_ADDR, status);
    for (int i = 0; i < 2 * N; i++) begin
      host_read(mm_pkg::SEL_C, cb + i);
    end
    for (int i = 0; i < N; i++) begin
      host_read(mm_pkg::SEL_A, ab + i * st);
      host_read(mm_pkg::SEL_B, bb + i * st);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin : main
    logic [31:0] rd;
    PRESETn = 1'b0;
    PADDR = '0;
    PWRITE = 1'b0;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWDATA = '0;
    bram_select = '0;
    bram_addr_ext = '0;
    bram_wdata_ext = '0;
    bram_we_ext = '0;
    host_rd = 1'b0;
    cycles = 0;
    $readmemh("test/mm_patterns.hex", pat);
    repeat (2) @(posedge clk);
    @(negedge clk);
    PRESETn = 1'b1;

    // Reset values, then read back of written values
    apb_read(mm_pkg::REG_STDN_TPU_ADDR, rd);
    apb_read(mm_pkg::REG_MATRIX_A_ADDR, rd);
    apb_read(mm_pkg::REG_MATRIX_B_ADDR, rd);
    apb_read(mm_pkg::REG_MATRIX_C_ADDR, rd);
    apb_read(mm_pkg::REG_MATRIX_A_STRIDE_ADDR, rd);
    apb_read(mm_pkg::REG_MATRIX_B_STRIDE_ADDR, rd);
    apb_read(mm_pkg::REG_MATRIX_C_STRIDE_ADDR, rd);
    apb_write(mm_pkg::REG_MATRIX_A_ADDR, 32'h5a5a_1234);
    apb_write(mm_pkg::REG_MATRIX_B_STRIDE_ADDR, 32'h0000_beef);
    apb_write(8'h40, 32'hffff_ffff);
    apb_read(mm_pkg::REG_MATRIX_A_ADDR, rd);
    apb_read(mm_pkg::REG_MATRIX_B_STRIDE_ADDR, rd);
    apb_read(8'h40, rd);

    run_matrix(0, 0, 16, 32, 1);
    run_matrix(1, 64, 80, 96, 2);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
verilog/mm_pkg.sv
verilog/mm_row_ram.sv
verilog/mm_matrix_store.sv
verilog/mm_apb_regs.sv
verilog/mm_operand_fetch.sv
verilog/mm_dot_product.sv
verilog/mm_result_writer.sv
verilog/matrix_multiplication.sv
test/tb_clock_gen.sv
test/tb_checker.sv
test/tb_matrix_multiplication.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the matrix multiplication testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_matrix_multiplication -o sim_tb --Mdir obj_dir \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log && echo "PASS (see sim.log)" && exit 0 \
  || { echo "FAIL (see sim.log)"; exit 1; }

//--- test/mm_patterns.hex
// Per run: 4 A rows, 4 B columns (B transposed), 4 expected C rows
// Element k of a word sits in byte k, element 0 in the low byte
// Run 1 A rows
04030201
05040302
06050403
07060504
// Run 1 B columns
01010101
02020202
03030303
04040404
// Run 1 expected C rows
281e140a
382a1c0e
48362412
58422c16
// Run 2 A rows
10101010
30303030
50505050
f0f0f0f0
// Run 2 B columns
04030201
05040302
06050403
07060504
// Run 2 expected C rows, truncated to 8 bits
6020e0a0
2060a0e0
e0a06020
a0e02060
